// File: wb_interconnect.f
+incdir+common
common/wb_pkg.sv
hw/wb_priority_arbiter.sv
hw/wb_bus_delay.sv
fabric/wb_addr_decoder.sv
fabric/wb_reg_bank.sv
fabric/wb_response_merge.sv
hw/wb_interconnect_top.sv
verif/tb_clock_gen.sv
verif/wb_interconnect_properties.sv
verif/wb_interconnect_tb.sv

// File: verif/wb_interconnect_tb.sv
/*
 * Directed tests for the interconnect, RAM responder model, timeout
 */
`timescale 1ns/1ps
`include "wb_interconnect_settings.svh"

module wb_interconnect_tb;

	// Bank test dominates with 64 accesses of about 8 cycles each
	localparam int MAX_CYCLES = 2000;

	logic                  clk;
	logic                  rst_n;
	wb_pkg::wb_req_t       cpu_req;
	wb_pkg::wb_req_t       host_req;
	wb_pkg::wb_rsp_t       cpu_rsp;
	wb_pkg::wb_rsp_t       host_rsp;
	logic                  ram_cyc;
	logic                  ram_stb;
	logic                  ram_we;
	logic [`WB_RAM_AW-1:0] ram_addr;
	logic [`WB_DATA_W-1:0] ram_wdata;
	logic                  ram_ack = 1'b0;
	logic                  ram_stall = 1'b0;
	logic                  ram_err = 1'b0;
	logic [`WB_DATA_W-1:0] ram_rdata = '0;
	logic [`WB_ADDR_W-1:0] bus_err_addr;

	int          err_count;
	int          check_count;
	int          test_count;
	int          cycle_count;
	logic [31:0] lcg_state = 32'h4084c513;
	// Expected register bank contents indexed by bank*8 + reg
	logic [31:0] shadow [32];
	// Requests the RAM model took and the fields of the last one
	int          ram_taken;
	logic        cap_we;
	logic [`WB_RAM_AW-1:0] cap_addr;
	logic [31:0] cap_wdata;
	int          stall_cnt;
	// RAM model stalls strobes only during the RAM test
	logic        ram_stall_en = 1'b0;

	tb_clock_gen u_clk (.o_clk(clk), .o_rst_n(rst_n));

	wb_interconnect_top u_dut (
		.i_clk (clk), .i_rst_n (rst_n),
		.i_cpu_req (cpu_req), .i_host_req (host_req),
		.o_cpu_rsp (cpu_rsp), .o_host_rsp (host_rsp),
		.o_ram_cyc (ram_cyc), .o_ram_stb (ram_stb), .o_ram_we (ram_we),
		.o_ram_addr (ram_addr), .o_ram_wdata (ram_wdata),
		.i_ram_ack (ram_ack), .i_ram_stall (ram_stall), .i_ram_err (ram_err),
		.i_ram_rdata (ram_rdata), .o_bus_err_addr (bus_err_addr)
	);

	bind wb_interconnect_top wb_interconnect_properties u_props (
		.i_clk (i_clk), .i_rst_n (i_rst_n), .i_cpu_req (i_cpu_req),
		.i_host_req (i_host_req), .o_cpu_rsp (o_cpu_rsp),
		.o_host_rsp (o_host_rsp), .o_ram_stb (o_ram_stb)
	);

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_cond(input bit ok, input string what);
		check_count++;
		assert (ok) else
		begin
			$display("FAIL %0t: %s", $time, what);
			err_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		if (err_count == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, err_count - errs_before);
	endtask

	task automatic drive_req(input bit host, input wb_pkg::wb_req_t req);
		if (host)
			host_req <= req;
		else
			cpu_req <= req;
	endtask

	function automatic wb_pkg::wb_rsp_t rsp_of(input bit host);
		return host ? host_rsp : cpu_rsp;
	endfunction

	// One single access that leaves cyc high
	task automatic bus_access(input bit host, input bit we, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output bit got_err,
		output int lat);
		wb_pkg::wb_req_t req;
		wb_pkg::wb_rsp_t rsp;
		int guard;
		req = '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, data: wdata};
		@(posedge clk);
		drive_req(host, req);
		guard = 0;
		@(negedge clk);
		rsp = rsp_of(host);
		while (rsp.stall && guard < 100)
		begin
			guard++;
			@(negedge clk);
			rsp = rsp_of(host);
		end
		if (guard >= 100)
		begin
			$display("Strobe never accepted at address %h", addr);
			err_count++;
		end
		@(posedge clk);
		req.stb = 1'b0;
		drive_req(host, req);
		lat = 0;
		do
		begin
			@(negedge clk);
			lat++;
			rsp = rsp_of(host);
		end while (!rsp.ack && !rsp.err && lat < 60);
		if (lat >= 60)
		begin
			$display("No ack or err came back for address %h", addr);
			err_count++;
		end
		rdata   = rsp.data;
		got_err = rsp.err;
	endtask

	task automatic release_bus(input bit host);
		@(posedge clk);
		drive_req(host, '0);
	endtask

	//////////////////////////////////////////////////
	// RAM responder model
	//////////////////////////////////////////////////

	// Stalls each strobe a random number of cycles while enabled
	// Read data is the inverted address
	always @(posedge clk)
	begin
		ram_ack <= 1'b0;
		if (!rst_n)
		begin
			stall_cnt <= 0;
			ram_stall <= 1'b0;
			ram_taken <= 0;
		end
		else if (ram_stb && !ram_stall)
		begin
			ram_ack   <= 1'b1;
			ram_rdata <= ~{{(32-`WB_RAM_AW){1'b0}}, ram_addr};
			cap_we    <= ram_we;
			cap_addr  <= ram_addr;
			cap_wdata <= ram_wdata;
			ram_taken <= ram_taken + 1;
			// Wait count for the next strobe
			stall_cnt <= int'(lcg_next() % 4);
			ram_stall <= ram_stall_en;
		end
		else if (ram_stb && stall_cnt != 0)
			stall_cnt <= stall_cnt - 1;
		// Idle stall while enabled, dropped once a waiting strobe runs out its count
		else
			ram_stall <= ram_stall_en && !ram_stb;
	end

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_reset();
		int e0;
		e0 = err_count;
		repeat (3)
		begin
			@(negedge clk);
			check_cond(!cpu_rsp.ack && !cpu_rsp.err, "CPU port response after reset");
			check_cond(!host_rsp.ack && !host_rsp.err, "host port response after reset");
			check_cond(!ram_stb && !ram_cyc, "RAM strobe or cycle after reset");
			check_cond(bus_err_addr == '0, "error address not zero after reset");
		end
		report_test("reset", e0);
	endtask

	task automatic test_banks();
		int e0;
		int lat;
		bit got_err;
		logic [31:0] rd;
		e0 = err_count;
		for (int i = 0; i < 32; i++)
		begin
			shadow[i] = lcg_next();
			bus_access(1'b1, 1'b1, i, shadow[i], rd, got_err, lat);
			check_cond(!got_err && lat == 4, $sformatf("bank write %0d lat %0d", i, lat));
		end
		for (int i = 0; i < 32; i++)
		begin
			bus_access(1'b1, 1'b0, i, 32'h0, rd, got_err, lat);
			check_cond(!got_err && lat == 4, $sformatf("bank read %0d lat %0d", i, lat));
			check_cond(rd == shadow[i],
				$sformatf("bank read %0d got %h expected %h", i, rd, shadow[i]));
		end
		release_bus(1'b1);
		report_test("banks", e0);
	endtask

	task automatic test_ram();
		int e0;
		int lat;
		int taken;
		bit got_err;
		logic [31:0] addr;
		logic [31:0] wd;
		logic [31:0] rd;
		e0 = err_count;
		@(posedge clk);
		ram_stall_en <= 1'b1;
		for (int i = 0; i < 8; i++)
		begin
			// RAM select bit set, top bits clear
			addr  = 32'h0400_0000 | (lcg_next() & 32'h03ff_ffff);
			wd    = lcg_next();
			taken = ram_taken;
			bus_access(1'b0, i[0], addr, wd, rd, got_err, lat);
			check_cond(!got_err, "RAM access returned err");
			check_cond(ram_taken == taken + 1, "RAM request lost or repeated");
			check_cond(cap_addr == addr[`WB_RAM_AW-1:0] && cap_we == i[0],
				$sformatf("RAM address or we wrong, got %h", cap_addr));
			if (i[0])
				check_cond(cap_wdata == wd, $sformatf("RAM write data %h", cap_wdata));
			else
				check_cond(rd == ~{6'b0, addr[25:0]}, $sformatf("RAM read data %h", rd));
		end
		release_bus(1'b0);
		ram_stall_en <= 1'b0;
		report_test("ram", e0);
	endtask

	task automatic test_unmapped();
		int e0;
		int lat;
		bit got_err;
		logic [31:0] rd;
		logic [31:0] bad [3];
		e0 = err_count;
		// Top-zero bit, a middle bit and bank index 4
		bad = '{32'h0800_0000, 32'h0010_0000, 32'h0000_0020};
		foreach (bad[i])
		begin
			bus_access(1'b0, 1'b0, bad[i], 32'h0, rd, got_err, lat);
			check_cond(got_err && !cpu_rsp.ack && lat == 4,
				$sformatf("no err for %h or err at lat %0d", bad[i], lat));
			check_cond(bus_err_addr == bad[i],
				$sformatf("error address %h expected %h", bus_err_addr, bad[i]));
			repeat (4)
			begin
				@(negedge clk);
				check_cond(!cpu_rsp.ack, "ack after unmapped access");
			end
		end
		release_bus(1'b0);
		report_test("unmapped", e0);
	endtask

	task automatic test_arbitration();
		int e0;
		int lat;
		bit cpu_done;
		bit got_err;
		logic [31:0] rd;
		logic [31:0] v;
		e0 = err_count;
		cpu_done = 1'b0;
		v = lcg_next();
		@(posedge clk);
		host_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, addr: 32'd17, data: 32'h0};
		cpu_req  <= '{cyc: 1'b1, stb: 1'b0, we: 1'b0, addr: 32'h0, data: 32'h0};
		fork
			begin
				bus_access(1'b0, 1'b1, 32'd13, v, rd, got_err, lat);
				shadow[13] = v;
				bus_access(1'b0, 1'b0, 32'd13, 32'h0, rd, got_err, lat);
				check_cond(rd == v, $sformatf("CPU readback %h expected %h", rd, v));
				release_bus(1'b0);
				cpu_done = 1'b1;
			end
			begin
				while (!cpu_done)
				begin
					@(negedge clk);
					check_cond(host_rsp.stall && !host_rsp.ack && !host_rsp.err,
						"host port not stalled while CPU owns the bus");
				end
			end
		join
		bus_access(1'b1, 1'b0, 32'd17, 32'h0, rd, got_err, lat);
		check_cond(!got_err && rd == shadow[17], $sformatf("host read %h after CPU", rd));
		release_bus(1'b1);
		report_test("arbitration", e0);
	endtask

	task automatic test_pipeline();
		int e0;
		int got;
		int guard;
		logic [31:0] exp_q [$];
		e0 = err_count;
		@(posedge clk);
		host_req <= '{cyc: 1'b1, stb: 1'b0, we: 1'b0, addr: 32'h0, data: 32'h0};
		@(negedge clk);
		while (host_rsp.stall)
			@(negedge clk);
		fork
			for (int i = 0; i < 8; i++)
			begin
				@(posedge clk);
				host_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, addr: 3 * i + 2, data: 32'h0};
				exp_q.push_back(shadow[3 * i + 2]);
				@(negedge clk);
				check_cond(!host_rsp.stall, "stall during back-to-back bank reads");
			end
			begin
				got = 0;
				guard = 0;
				while (got < 8 && guard < 60)
				begin
					@(negedge clk);
					guard++;
					if (host_rsp.ack)
					begin
						check_cond(host_rsp.data == exp_q[got],
							$sformatf("pipelined read %0d got %h", got, host_rsp.data));
						got++;
					end
				end
			end
		join_any
		@(posedge clk);
		host_req.stb <= 1'b0;
		wait fork;
		check_cond(got == 8, $sformatf("%0d acks for 8 pipelined reads", got));
		repeat (6)
		begin
			@(negedge clk);
			check_cond(!host_rsp.ack, "extra ack after pipelined reads");
		end
		release_bus(1'b1);
		report_test("pipeline", e0);
	endtask

	//////////////////////////////////////////////////
	// Sequence and timeout
	//////////////////////////////////////////////////

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Run stopped after %0d cycles, a test never finished", MAX_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial
	begin
		cpu_req  = '0;
		host_req = '0;
		wait (rst_n === 1'b1);
		test_reset();
		test_banks();
		test_ram();
		test_unmapped();
		test_arbitration();
		test_pipeline();
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: verif/wb_interconnect_properties.sv
/*
 * Concurrent assertions on the master ports and the RAM strobe
 */
`timescale 1ns/1ps

module wb_interconnect_properties (
	input logic            i_clk,
	input logic            i_rst_n,
	input wb_pkg::wb_req_t i_cpu_req,
	input wb_pkg::wb_req_t i_host_req,
	input wb_pkg::wb_rsp_t o_cpu_rsp,
	input wb_pkg::wb_rsp_t o_host_rsp,
	input logic            o_ram_stb
);

	// Accepted strobes still waiting for ack or err
	int cpu_open;
	int host_open;

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || !i_cpu_req.cyc)
			cpu_open <= 0;
		else
			cpu_open <= cpu_open + int'(i_cpu_req.stb && !o_cpu_rsp.stall)
				- int'(o_cpu_rsp.ack || o_cpu_rsp.err);
		if (!i_rst_n || !i_host_req.cyc)
			host_open <= 0;
		else
			host_open <= host_open + int'(i_host_req.stb && !o_host_rsp.stall)
				- int'(o_host_rsp.ack || o_host_rsp.err);
	end

	//////////////////////////////////////////////////
	// Properties
	//////////////////////////////////////////////////

	a_cpu_ack_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_cpu_rsp.ack && o_cpu_rsp.err)) else $error("CPU port ack and err together");
	a_host_ack_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_host_rsp.ack && o_host_rsp.err)) else $error("Host port ack and err together");

	// Every ack answers an earlier accepted strobe
	a_cpu_ack_open: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_cpu_rsp.ack |-> cpu_open > 0) else $error("CPU port ack without a strobe");
	a_host_ack_open: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_host_rsp.ack |-> host_open > 0) else $error("Host port ack without a strobe");

	a_ram_stb_rst: assert property (@(posedge i_clk)
		!i_rst_n |=> !o_ram_stb) else $error("RAM strobe high right after reset");

endmodule

// File: verif/tb_clock_gen.sv
/*
 * Testbench clock, 8 ns period, reset low for the first 2 cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst_n
);

	initial
	begin
		o_clk   = 1'b0;
		o_rst_n = 1'b0;
		repeat (2) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

	always #4 o_clk = !o_clk;

endmodule

// File: hw/wb_interconnect_top.sv
/*
 * Interconnect top: arbiter, delay stage, decoder, banks, merger, RAM port
 */
`timescale 1ns/1ps
`include "wb_interconnect_settings.svh"

module wb_interconnect_top (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  wb_pkg::wb_req_t       i_cpu_req,
	input  wb_pkg::wb_req_t       i_host_req,
	output wb_pkg::wb_rsp_t       o_cpu_rsp,
	output wb_pkg::wb_rsp_t       o_host_rsp,
	output logic                  o_ram_cyc,
	output logic                  o_ram_stb,
	output logic                  o_ram_we,
	output logic [`WB_RAM_AW-1:0] o_ram_addr,
	output logic [`WB_DATA_W-1:0] o_ram_wdata,
	input  logic                  i_ram_ack,
	input  logic                  i_ram_stall,
	input  logic                  i_ram_err,
	input  logic [`WB_DATA_W-1:0] i_ram_rdata,
	output logic [`WB_ADDR_W-1:0] o_bus_err_addr
);

	// Arbiter side and fabric side of the delay stage
	wb_pkg::wb_req_t   arb_req;
	wb_pkg::wb_rsp_t   arb_rsp;
	wb_pkg::wb_req_t   fab_req;
	wb_pkg::wb_rsp_t   fab_rsp;
	wb_pkg::bank_sel_t bank_stb;
	logic              unmapped;
	logic [`WB_NUM_BANKS-1:0]                bank_ack;
	logic [`WB_NUM_BANKS-1:0][`WB_DATA_W-1:0] bank_data;

	//////////////////////////////////////////////////
	// Masters to the fabric
	//////////////////////////////////////////////////

	wb_priority_arbiter u_arbiter (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_cpu_req  (i_cpu_req),
		.i_host_req (i_host_req),
		.o_cpu_rsp  (o_cpu_rsp),
		.o_host_rsp (o_host_rsp),
		.o_bus_req  (arb_req),
		.i_bus_rsp  (arb_rsp)
	);

	wb_bus_delay u_delay (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_up_req (arb_req),
		.o_up_rsp (arb_rsp),
		.o_dn_req (fab_req),
		.i_dn_rsp (fab_rsp)
	);

	//////////////////////////////////////////////////
	// Fabric
	//////////////////////////////////////////////////

	wb_addr_decoder u_decoder (
		.i_req      (fab_req),
		.o_bank_stb (bank_stb),
		.o_ram_stb  (o_ram_stb),
		.o_unmapped (unmapped)
	);

	for (genvar b = 0; b < `WB_NUM_BANKS; b++)
	begin : g_bank
		wb_reg_bank u_bank (
			.i_clk   (i_clk),
			.i_rst_n (i_rst_n),
			.i_stb   (bank_stb[b]),
			.i_req   (fab_req),
			.o_ack   (bank_ack[b]),
			.o_data  (bank_data[b])
		);
	end

	wb_response_merge u_merge (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_req          (fab_req),
		.i_bank_ack     (bank_ack),
		.i_bank_data    (bank_data),
		.i_unmapped     (unmapped),
		.i_ram_ack      (i_ram_ack),
		.i_ram_stall    (i_ram_stall),
		.i_ram_err      (i_ram_err),
		.i_ram_data     (i_ram_rdata),
		.o_rsp          (fab_rsp),
		.o_bus_err_addr (o_bus_err_addr)
	);

	// Off-chip RAM controller port
	assign o_ram_cyc   = fab_req.cyc;
	assign o_ram_we    = fab_req.we;
	assign o_ram_addr  = fab_req.addr[`WB_RAM_AW-1:0];
	assign o_ram_wdata = fab_req.data;

endmodule

// File: fabric/wb_response_merge.sv
/*
 * Registered ack/data merge, bus error detection, error address capture
 */
`timescale 1ns/1ps
`include "wb_interconnect_settings.svh"

module wb_response_merge (
	input  logic                                    i_clk,
	input  logic                                    i_rst_n,
	input  wb_pkg::wb_req_t                         i_req,
	input  logic [`WB_NUM_BANKS-1:0]                i_bank_ack,
	input  logic [`WB_NUM_BANKS-1:0][`WB_DATA_W-1:0] i_bank_data,
	input  logic                                    i_unmapped,
	input  logic                                    i_ram_ack,
	input  logic                                    i_ram_stall,
	input  logic                                    i_ram_err,
	input  logic [`WB_DATA_W-1:0]                   i_ram_data,
	output wb_pkg::wb_rsp_t                         o_rsp,
	output logic [`WB_ADDR_W-1:0]                   o_bus_err_addr
);

	// Banks plus the RAM port
	localparam int NSRC = `WB_NUM_BANKS + 1;

	logic [NSRC-1:0]       ack_vec;
	logic                  many_ack;
	logic                  fab_stall;
	logic                  err_d;
	logic                  unmapped_q;
	logic                  ack_q;
	logic                  err_q;
	logic [`WB_DATA_W-1:0] data_d;
	logic [`WB_DATA_W-1:0] data_q;
	// Address of the last strobe on the fabric
	logic [`WB_ADDR_W-1:0] addr_q;

	assign ack_vec = {i_ram_ack, i_bank_ack};

	// More than one bit set
	assign many_ack = |(ack_vec & (ack_vec - 1'b1));

	assign fab_stall = i_req.cyc && i_ram_stall;

	//////////////////////////////////////////////////
	// Error sources
	//////////////////////////////////////////////////

	// Delayed unmapped flag lands where a bank ack would
	assign err_d = i_req.cyc && (many_ack || unmapped_q || i_ram_err);

	// Source data mux, RAM when no bank acks
	always_comb
	begin
		data_d = i_ram_data;
		for (int b = 0; b < `WB_NUM_BANKS; b++)
			if (i_bank_ack[b])
				data_d = i_bank_data[b];
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			unmapped_q     <= 1'b0;
			ack_q          <= 1'b0;
			err_q          <= 1'b0;
			o_bus_err_addr <= '0;
		end
		else
		begin
			// Only strobes actually taken count
			unmapped_q <= i_unmapped && !fab_stall;
			// Err replaces ack, never both
			ack_q <= i_req.cyc && (|ack_vec) && !err_d;
			err_q <= err_d;
			if (err_d)
				o_bus_err_addr <= addr_q;
		end
	end

	always_ff @(posedge i_clk)
	begin
		data_q <= data_d;
		if (i_req.cyc && i_req.stb)
			addr_q <= i_req.addr;
	end

	// Stall straight through from the RAM port
	assign o_rsp = '{ack: ack_q, stall: fab_stall, err: err_q, data: data_q};

endmodule

// File: fabric/wb_reg_bank.sv
/*
 * Eight read/write registers, ack one cycle after the strobe
 */
`timescale 1ns/1ps
`include "wb_interconnect_settings.svh"

module wb_reg_bank (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_stb,
	input  wb_pkg::wb_req_t       i_req,
	output logic                  o_ack,
	output logic [`WB_DATA_W-1:0] o_data
);

	localparam int IDX_W = $clog2(`WB_BANK_REGS);

	logic [`WB_DATA_W-1:0] regs [`WB_BANK_REGS];
	// Register select from the low address bits
	logic [IDX_W-1:0]      idx;

	assign idx = i_req.addr[IDX_W-1:0];

	// Never stalls, so every strobe is acked next cycle
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			o_ack <= 1'b0;
			for (int r = 0; r < `WB_BANK_REGS; r++)
				regs[r] <= '0;
		end
		else
		begin
			o_ack <= i_stb;
			if (i_stb && i_req.we)
				regs[idx] <= i_req.data;
		end
	end

	// Read returns the contents before this cycle's write
	always_ff @(posedge i_clk)
	begin
		if (i_stb)
			o_data <= regs[idx];
	end

endmodule

// File: fabric/wb_addr_decoder.sv
/*
 * Skip-bit address decode into bank strobes, RAM strobe, unmapped flag
 */
`timescale 1ns/1ps
`include "wb_interconnect_settings.svh"

module wb_addr_decoder (
	input  wb_pkg::wb_req_t   i_req,
	output wb_pkg::bank_sel_t o_bank_stb,
	output logic              o_ram_stb,
	output logic              o_unmapped
);

	// Bank index field width and the first bit above it
	localparam int IDX_W   = $clog2(`WB_NUM_BANKS);
	localparam int MID_LSB = `WB_BANK_IDX_LSB + IDX_W;

	logic             req_stb;
	logic             top_err;
	logic             ram_hit;
	logic             bank_hit;
	logic [IDX_W-1:0] bank_idx;

	assign req_stb = i_req.cyc && i_req.stb;

	//////////////////////////////////////////////////
	// Region select
	//////////////////////////////////////////////////

	// High bits must be clear for anything legal
	assign top_err = |i_req.addr[`WB_ADDR_W-1:`WB_TOP_ZERO_LSB];

	// RAM bit set, lower bits are the RAM word address
	assign ram_hit = !top_err && i_req.addr[`WB_RAM_SEL_BIT];

	// Bank space needs every bit between index and RAM bit clear
	assign bank_hit = !top_err && !i_req.addr[`WB_RAM_SEL_BIT]
		&& !(|i_req.addr[`WB_RAM_SEL_BIT-1:MID_LSB]);

	assign bank_idx = i_req.addr[MID_LSB-1:`WB_BANK_IDX_LSB];

	//////////////////////////////////////////////////
	// Strobes
	//////////////////////////////////////////////////

	always_comb
	begin
		for (int b = 0; b < `WB_NUM_BANKS; b++)
			o_bank_stb[b] = req_stb && bank_hit && (bank_idx == b);
	end

	assign o_ram_stb = req_stb && ram_hit;

	// Nobody claims it, the merger turns this into err
	assign o_unmapped = req_stb && !ram_hit && !(|o_bank_stb);

endmodule

// File: hw/wb_bus_delay.sv
/*
 * One registered stage on the request and response paths
 */
`timescale 1ns/1ps
`include "wb_interconnect_settings.svh"

module wb_bus_delay (
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  wb_pkg::wb_req_t i_up_req,
	output wb_pkg::wb_rsp_t o_up_rsp,
	output wb_pkg::wb_req_t o_dn_req,
	input  wb_pkg::wb_rsp_t i_dn_rsp
);

	// Downstream request register
	logic                  dn_cyc;
	logic                  dn_stb;
	logic                  dn_we;
	logic [`WB_ADDR_W-1:0] dn_addr;
	logic [`WB_DATA_W-1:0] dn_data;
	// Upstream response register
	logic                  up_ack;
	logic                  up_err;
	logic [`WB_DATA_W-1:0] up_data;
	// Held strobe not yet taken downstream
	logic                  hold;

	assign hold = dn_stb && i_dn_rsp.stall;

	//////////////////////////////////////////////////
	// Request path
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			dn_cyc <= 1'b0;
			dn_stb <= 1'b0;
		end
		else
		begin
			dn_cyc <= i_up_req.cyc;
			// Dropped cyc aborts a pending strobe
			if (!i_up_req.cyc)
				dn_stb <= 1'b0;
			else if (!hold)
				dn_stb <= i_up_req.stb;
		end
	end

	// Payload follows the strobe, frozen while held
	always_ff @(posedge i_clk)
	begin
		if (!hold)
		begin
			dn_we   <= i_up_req.we;
			dn_addr <= i_up_req.addr;
			dn_data <= i_up_req.data;
		end
	end

	assign o_dn_req = '{cyc: dn_cyc, stb: dn_stb, we: dn_we, addr: dn_addr, data: dn_data};

	//////////////////////////////////////////////////
	// Response path
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			up_ack <= 1'b0;
			up_err <= 1'b0;
		end
		else
		begin
			up_ack <= i_up_req.cyc && i_dn_rsp.ack;
			up_err <= i_up_req.cyc && i_dn_rsp.err;
		end
	end

	always_ff @(posedge i_clk)
		up_data <= i_dn_rsp.data;

	// Stall back to the master straight from the held strobe
	assign o_up_rsp = '{ack: up_ack, stall: hold, err: up_err, data: up_data};

endmodule

// File: hw/wb_priority_arbiter.sv
/*
 * Two-master priority arbiter, CPU port first, owner holds the bus
 */
`timescale 1ns/1ps

module wb_priority_arbiter (
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  wb_pkg::wb_req_t i_cpu_req,
	input  wb_pkg::wb_req_t i_host_req,
	output wb_pkg::wb_rsp_t o_cpu_rsp,
	output wb_pkg::wb_rsp_t o_host_rsp,
	output wb_pkg::wb_req_t o_bus_req,
	input  wb_pkg::wb_rsp_t i_bus_rsp
);

	// Current owner, low means CPU port
	logic host_owner;
	// Owner has let go of the bus
	logic owner_idle;

	assign owner_idle = host_owner ? !i_host_req.cyc : !i_cpu_req.cyc;

	// Grant moves only between bus cycles
	// CPU wins whenever it asks, host only when CPU is quiet
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			host_owner <= 1'b0;
		else if (owner_idle)
			host_owner <= !i_cpu_req.cyc && i_host_req.cyc;
	end

	// Owner's request goes downstream untouched
	assign o_bus_req = host_owner ? i_host_req : i_cpu_req;

	//////////////////////////////////////////////////
	// Response steering
	//////////////////////////////////////////////////

	always_comb
	begin
		o_cpu_rsp  = i_bus_rsp;
		o_host_rsp = i_bus_rsp;
		if (host_owner)
		begin
			// CPU waits on stall
			o_cpu_rsp.ack   = 1'b0;
			o_cpu_rsp.err   = 1'b0;
			o_cpu_rsp.stall = 1'b1;
		end
		else
		begin
			// Host waits on stall
			o_host_rsp.ack   = 1'b0;
			o_host_rsp.err   = 1'b0;
			o_host_rsp.stall = 1'b1;
		end
	end

endmodule

// File: common/wb_pkg.sv
/*
 * Wishbone request and response structs, bank strobe vector
 */
`include "wb_interconnect_settings.svh"

package wb_pkg;

	//////////////////////////////////////////////////
	// Master to slave
	//////////////////////////////////////////////////

	// Pipelined request, one transfer per stb without stall
	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [`WB_ADDR_W-1:0] addr;
		logic [`WB_DATA_W-1:0] data;
	} wb_req_t;

	//////////////////////////////////////////////////
	// Slave to master
	//////////////////////////////////////////////////

	// One ack or err per accepted request
	// Stall is combinational
	typedef struct packed {
		logic                  ack;
		logic                  stall;
		logic                  err;
		logic [`WB_DATA_W-1:0] data;
	} wb_rsp_t;

	// One-hot register bank strobes
	typedef logic [`WB_NUM_BANKS-1:0] bank_sel_t;

endpackage

// File: common/wb_interconnect_settings.svh
/*
 * Bus widths, register bank sizing and address-map bit positions
 */
`ifndef WB_INTERCONNECT_SETTINGS_SVH
`define WB_INTERCONNECT_SETTINGS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

// Data bus width
`define WB_DATA_W 32
// Word address width on the fabric
`define WB_ADDR_W 32
// Address width of the off-chip RAM port
`define WB_RAM_AW 26

//////////////////////////////////////////////////
// Register banks
//////////////////////////////////////////////////

// Banks in the generate loop
`define WB_NUM_BANKS 4
// 32-bit registers per bank
`define WB_BANK_REGS 8

//////////////////////////////////////////////////
// Address map skip bits
//////////////////////////////////////////////////

// Set means RAM
`define WB_RAM_SEL_BIT 26
// Bank index starts just above the register index
`define WB_BANK_IDX_LSB 3
// Everything from here up must be zero
`define WB_TOP_ZERO_LSB 27

`endif
